// ==== common/ip4_defs.svh ====
`ifndef IP4_DEFS_SVH
`define IP4_DEFS_SVH

// Stream bus geometry
`define IP4_BUS_BYTES 8

// Byte offsets into an untagged Ethernet frame
`define IP4_PROT_OFFSET 23
`define IP4_SA_OFFSET 26
`define IP4_DA_OFFSET 30

// Field sizes in bits
`define IP4_PROTO_BITS 8
`define IP4_ADDR_BITS 32

// Extra bytes ahead of the IPv4 header when one VLAN tag is present
`define IP4_VLAN_BYTES 4

// Beat index width covers the longest frame of interest
`define IP4_BEAT_CBITS 8

`endif

// ==== common/axis_pkg.sv ====
`default_nettype none

`include "ip4_defs.svh"

package axis_pkg;

    // One beat of the byte stream with lane 0 in the low bits of tdata
    typedef struct packed {
        logic [`IP4_BUS_BYTES*8-1:0] tdata;
        logic [`IP4_BUS_BYTES-1:0]   tkeep;
        logic                        tlast;
    } axis_beat_t;

    // Beat index within a frame
    typedef logic [`IP4_BEAT_CBITS-1:0] beat_pos_t;

endpackage

`default_nettype wire

// ==== common/ip4_pkg.sv ====
`default_nettype none

`include "ip4_defs.svh"

package ip4_pkg;

    // First wire byte is the most significant byte
    typedef logic [`IP4_ADDR_BITS-1:0]  ip4_addr_t;
    typedef logic [`IP4_PROTO_BITS-1:0] ip4_proto_t;

    // Quasi-static access configuration
    typedef struct packed {
        logic      restrict_to_ports;
        logic      match_src;
        ip4_addr_t src_address;
        ip4_addr_t dest_address;
        ip4_addr_t subnet_mask;
        logic      allow_public;
        logic      allow_bc;
        logic      allow_mc;
    } acl_cfg_t;

    // Side-channel result to the next stage
    typedef struct packed {
        logic parsing_done;
        logic poisoned;
        logic next_has_ports;
        logic next_is_udp;
    } parse_result_t;

    // Next-header classification
    typedef struct packed {
        logic has_ports;
        logic is_udp;
    } proto_class_t;

endpackage

`default_nettype wire

// ==== src/beat_counter.sv ====
`default_nettype none

module beat_counter (
    input  logic                aclk,
    input  logic                rst,
    input  logic                beat_fire,
    input  logic                beat_last,
    output axis_pkg::beat_pos_t pos
);

    // Restart on the last beat, hold at the top on very long frames
    always_ff @(posedge aclk) begin
        if (rst || beat_last) begin
            pos <= '0;
        end else if (beat_fire && pos != '1) begin
            pos <= pos + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_phase_fsm.sv ====
`default_nettype none

module frame_phase_fsm (
    input  logic aclk,
    input  logic rst,
    input  logic beat_fire,
    input  logic beat_last,
    input  logic dest_complete,
    output logic parsing_done,
    output logic runt
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        DONE
    } phase_t;

    phase_t state_q;
    phase_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (beat_last) begin
                    state_d = IDLE;
                end else if (beat_fire) begin
                    state_d = dest_complete ? DONE : HEADER;
                end
            end
            HEADER: begin
                if (beat_last) begin
                    state_d = IDLE;
                end else if (beat_fire && dest_complete) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                if (beat_last) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Done from the deciding beat onward
    assign parsing_done = (state_q == DONE) || (beat_fire && dest_complete);

    // Frame ended before the destination address was in
    assign runt = beat_last && !parsing_done;

endmodule

`default_nettype wire

// ==== src/field_capture.sv ====
`default_nettype none

`include "ip4_defs.svh"

module field_capture #(
    parameter type field_t = ip4_pkg::ip4_addr_t,
    parameter int  OFFSET  = 0
) (
    input  logic                 aclk,
    input  logic                 rst,
    input  axis_pkg::axis_beat_t beat,
    input  logic                 beat_fire,
    input  logic                 beat_last,
    input  axis_pkg::beat_pos_t  pos,
    input  logic                 is_tagged,
    output field_t               value,
    output logic                 complete
);

    import axis_pkg::*;

    localparam int NBYTES    = $bits(field_t) / 8;
    localparam int LANE_BITS = $clog2(`IP4_BUS_BYTES);
    localparam int OFF_BITS  = `IP4_BEAT_CBITS + LANE_BITS;

    logic [OFF_BITS-1:0]  byte_off  [NBYTES];
    beat_pos_t            byte_beat [NBYTES];
    logic [LANE_BITS-1:0] byte_lane [NBYTES];
    logic [NBYTES-1:0]    present;
    logic [NBYTES-1:0]    seen_q;
    logic [NBYTES*8-1:0]  held_q;
    logic [NBYTES*8-1:0]  merged;

    // Locate every field byte as a beat index and a byte lane
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            byte_off[i] = OFF_BITS'(OFFSET + i);
            if (is_tagged) begin
                byte_off[i] = byte_off[i] + OFF_BITS'(`IP4_VLAN_BYTES);
            end
            byte_beat[i] = byte_off[i][OFF_BITS-1:LANE_BITS];
            byte_lane[i] = byte_off[i][LANE_BITS-1:0];
            present[i]   = beat_fire && (pos == byte_beat[i]) && beat.tkeep[byte_lane[i]];
            // Wire order is big endian
            if (present[i]) begin
                merged[(NBYTES-1-i)*8 +: 8] = beat.tdata[byte_lane[i]*8 +: 8];
            end else begin
                merged[(NBYTES-1-i)*8 +: 8] = held_q[(NBYTES-1-i)*8 +: 8];
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < NBYTES; i++) begin
            if (present[i]) begin
                held_q[(NBYTES-1-i)*8 +: 8] <= merged[(NBYTES-1-i)*8 +: 8];
            end
        end
    end

    // Seen mask starts clean for every frame
    always_ff @(posedge aclk) begin
        if (rst || beat_last) begin
            seen_q <= '0;
        end else begin
            seen_q <= seen_q | present;
        end
    end

    assign value    = field_t'(merged);
    assign complete = &(seen_q | present);

endmodule

`default_nettype wire

// ==== acl/dest_acl.sv ====
`default_nettype none

module dest_acl (
    input  ip4_pkg::ip4_addr_t dest,
    input  logic               dest_complete,
    input  ip4_pkg::acl_cfg_t  cfg,
    output logic               dest_poisoned
);

    import ip4_pkg::*;

    ip4_addr_t host_bits;
    ip4_addr_t subnet_bc_addr;
    logic      subnet_match;
    logic      is_ones_bc;
    logic      is_subnet_bc;
    logic      is_mc;
    logic      is_pri_10;
    logic      is_pri_172;
    logic      is_pri_192;
    logic      is_public;
    logic      public_ok;
    logic      bc_ok;
    logic      mc_ok;

    assign host_bits      = ~cfg.subnet_mask;
    assign subnet_bc_addr = cfg.dest_address | host_bits;

    // Same network as the configured address
    assign subnet_match = (dest & cfg.subnet_mask) == (cfg.dest_address & cfg.subnet_mask);

    // Limited and directed broadcast
    assign is_ones_bc   = &dest;
    assign is_subnet_bc = (dest == subnet_bc_addr);

    // 224.0.0.0/4
    assign is_mc = (dest[31:28] == 4'he);

    // RFC 1918 ranges
    assign is_pri_10  = (dest[31:24] == 8'd10);
    assign is_pri_172 = (dest[31:20] == 12'hac1);
    assign is_pri_192 = (dest[31:16] == 16'hc0a8);
    assign is_public  = !(is_pri_10 || is_pri_172 || is_pri_192);

    // Exceptions the configuration can open up
    assign public_ok = cfg.allow_public && is_public;
    assign bc_ok     = cfg.allow_bc && (is_ones_bc || is_subnet_bc);
    assign mc_ok     = cfg.allow_mc && is_mc;

    assign dest_poisoned = dest_complete && !(subnet_match || public_ok || bc_ok || mc_ok);

endmodule

`default_nettype wire

// ==== acl/header_acl.sv ====
`default_nettype none

module header_acl (
    input  ip4_pkg::ip4_proto_t   proto,
    input  logic                  proto_complete,
    input  ip4_pkg::ip4_addr_t    src,
    input  logic                  src_complete,
    input  ip4_pkg::acl_cfg_t     cfg,
    output ip4_pkg::proto_class_t proto_class,
    output logic                  proto_poisoned,
    output logic                  src_poisoned
);

    import ip4_pkg::*;

    // Protocols that carry a port pair
    localparam ip4_proto_t PROTO_TCP     = 8'd6;
    localparam ip4_proto_t PROTO_UDP     = 8'd17;
    localparam ip4_proto_t PROTO_DCCP    = 8'd33;
    localparam ip4_proto_t PROTO_SCTP    = 8'd132;
    localparam ip4_proto_t PROTO_UDPLITE = 8'd136;

    logic is_udp;
    logic has_ports;

    assign is_udp    = (proto == PROTO_UDP);
    assign has_ports = is_udp || (proto == PROTO_TCP) || (proto == PROTO_DCCP)
                       || (proto == PROTO_SCTP) || (proto == PROTO_UDPLITE);

    assign proto_class.has_ports = proto_complete && has_ports;
    assign proto_class.is_udp    = proto_complete && is_udp;

    assign proto_poisoned = proto_complete && !has_ports && cfg.restrict_to_ports;
    assign src_poisoned   = src_complete && cfg.match_src && (src != cfg.src_address);

endmodule

`default_nettype wire

// ==== src/ip4_parser.sv ====
`default_nettype none

`include "ip4_defs.svh"

module ip4_parser (
    input  logic                   aclk,
    input  logic                   rst,
    input  axis_pkg::axis_beat_t   s_beat,
    input  logic                   s_tvalid,
    output logic                   s_tready,
    output axis_pkg::axis_beat_t   m_beat,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    input  logic                   is_tagged,
    input  ip4_pkg::acl_cfg_t      cfg,
    output ip4_pkg::parse_result_t result
);

    import axis_pkg::*;
    import ip4_pkg::*;

    logic         beat_fire;
    logic         beat_last;
    beat_pos_t    pos;
    ip4_proto_t   proto;
    logic         proto_complete;
    ip4_addr_t    src_addr;
    logic         src_complete;
    ip4_addr_t    dest_addr;
    logic         dest_complete;
    proto_class_t proto_class;
    logic         proto_poisoned;
    logic         src_poisoned;
    logic         dest_poisoned;
    logic         parsing_done;
    logic         runt;

    // Stream is untouched
    assign m_beat   = s_beat;
    assign m_tvalid = s_tvalid;
    assign s_tready = m_tready;

    assign beat_fire = s_tvalid && m_tready;
    assign beat_last = beat_fire && s_beat.tlast;

    beat_counter beat_counter_i (
        .aclk      (aclk),
        .rst       (rst),
        .beat_fire (beat_fire),
        .beat_last (beat_last),
        .pos       (pos)
    );

    field_capture #(
        .field_t (ip4_proto_t),
        .OFFSET  (`IP4_PROT_OFFSET)
    ) proto_capture_i (
        .aclk      (aclk),
        .rst       (rst),
        .beat      (s_beat),
        .beat_fire (beat_fire),
        .beat_last (beat_last),
        .pos       (pos),
        .is_tagged (is_tagged),
        .value     (proto),
        .complete  (proto_complete)
    );

    field_capture #(
        .field_t (ip4_addr_t),
        .OFFSET  (`IP4_SA_OFFSET)
    ) src_capture_i (
        .aclk      (aclk),
        .rst       (rst),
        .beat      (s_beat),
        .beat_fire (beat_fire),
        .beat_last (beat_last),
        .pos       (pos),
        .is_tagged (is_tagged),
        .value     (src_addr),
        .complete  (src_complete)
    );

    field_capture #(
        .field_t (ip4_addr_t),
        .OFFSET  (`IP4_DA_OFFSET)
    ) dest_capture_i (
        .aclk      (aclk),
        .rst       (rst),
        .beat      (s_beat),
        .beat_fire (beat_fire),
        .beat_last (beat_last),
        .pos       (pos),
        .is_tagged (is_tagged),
        .value     (dest_addr),
        .complete  (dest_complete)
    );

    frame_phase_fsm frame_phase_fsm_i (
        .aclk          (aclk),
        .rst           (rst),
        .beat_fire     (beat_fire),
        .beat_last     (beat_last),
        .dest_complete (dest_complete),
        .parsing_done  (parsing_done),
        .runt          (runt)
    );

    header_acl header_acl_i (
        .proto          (proto),
        .proto_complete (proto_complete),
        .src            (src_addr),
        .src_complete   (src_complete),
        .cfg            (cfg),
        .proto_class    (proto_class),
        .proto_poisoned (proto_poisoned),
        .src_poisoned   (src_poisoned)
    );

    dest_acl dest_acl_i (
        .dest          (dest_addr),
        .dest_complete (dest_complete),
        .cfg           (cfg),
        .dest_poisoned (dest_poisoned)
    );

    // Any failed check or a short frame poisons the frame
    assign result.parsing_done   = parsing_done;
    assign result.poisoned       = proto_poisoned || src_poisoned || dest_poisoned || runt;
    assign result.next_has_ports = proto_class.has_ports;
    assign result.next_is_udp    = proto_class.is_udp;

endmodule

`default_nettype wire

// ==== sim/tb_ip4_parser.sv ====
`default_nettype none

`include "ip4_defs.svh"

module tb_ip4_parser;

    timeunit 1ns;
    timeprecision 1ps;

    import axis_pkg::*;
    import ip4_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int FRAME_COUNT  = 91;
    localparam int WATCHDOG_NS  = FRAME_COUNT * 20 * 4 + RESET_CYCLES * 4 + 2000;

    localparam logic [31:0] SRC_OK  = 32'h0a00_0001;
    localparam logic [31:0] SRC_BAD = 32'h0a00_0002;
    localparam logic [7:0]  PROTOS [7] = '{8'd6, 8'd17, 8'd33, 8'd132, 8'd136, 8'd1, 8'd47};
    // In subnet, private elsewhere, public, all ones, subnet broadcast, multicast
    localparam logic [31:0] DESTS [6] = '{32'hc0a8_0511, 32'h0a03_0405, 32'h0808_0404,
                                          32'hffff_ffff, 32'hc0a8_05ff, 32'hef01_0203};

    logic          aclk;
    logic          rst;
    axis_beat_t    s_beat;
    logic          s_tvalid;
    logic          s_tready;
    axis_beat_t    m_beat;
    logic          m_tvalid;
    logic          m_tready;
    logic          is_tagged;
    acl_cfg_t      cfg;
    parse_result_t result;

    int         seed;
    int         errors;
    int         checks;
    int         tests;
    int         frames;
    int         test_errors0;
    int         test_frames0;
    logic       first_beat;
    logic       exp_done;
    logic       exp_poison;
    logic       exp_ports;
    logic       exp_udp;
    logic [7:0] frame_bytes [64];

    ip4_parser ip4_parser_i (
        .aclk      (aclk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .m_beat    (m_beat),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .is_tagged (is_tagged),
        .cfg       (cfg),
        .result    (result)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the frames did not finish", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_beat(input string name, input axis_beat_t expected,
                              input axis_beat_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_result(input logic done, input logic poison, input logic ports,
                                input logic udp);
        check_bit("result.parsing_done", done, result.parsing_done);
        check_bit("result.poisoned", poison, result.poisoned);
        check_bit("result.next_has_ports", ports, result.next_has_ports);
        check_bit("result.next_is_udp", udp, result.next_is_udp);
    endtask

    // Outputs settle well before the next rising edge
    always @(negedge aclk) begin
        #1;
        if (!rst) begin
            check_bit("s_tready", m_tready, s_tready);
            check_bit("m_tvalid", s_tvalid, m_tvalid);
            check_beat("m_beat", s_beat, m_beat);
            if (s_tvalid && m_tready && first_beat) begin
                check_result(1'b0, 1'b0, 1'b0, 1'b0);
            end
            if (s_tvalid && m_tready && s_beat.tlast) begin
                check_result(exp_done, exp_poison, exp_ports, exp_udp);
            end
        end
    end

    function automatic acl_cfg_t base_cfg();
        acl_cfg_t c;
        c = '0;
        c.src_address  = SRC_OK;
        c.dest_address = 32'hc0a8_0500;
        c.subnet_mask  = 32'hffff_ff00;
        return c;
    endfunction

    // Reference model of the result at the frame's last beat
    task automatic expect_result(input logic [7:0] proto, input logic [31:0] src,
                                 input logic [31:0] dest, input logic vlan,
                                 input int nbytes);
        int   shift;
        logic proto_in;
        logic src_in;
        logic dest_in;
        logic ports;
        logic bcast;
        logic mcast;
        logic priv;
        logic dest_ok;
        shift    = vlan ? `IP4_VLAN_BYTES : 0;
        proto_in = (`IP4_PROT_OFFSET + shift + 1) <= nbytes;
        src_in   = (`IP4_SA_OFFSET + shift + 4) <= nbytes;
        dest_in  = (`IP4_DA_OFFSET + shift + 4) <= nbytes;
        ports    = proto inside {8'd6, 8'd17, 8'd33, 8'd132, 8'd136};
        bcast    = (dest == 32'hffff_ffff) || (dest == (cfg.dest_address | ~cfg.subnet_mask));
        mcast    = dest[31:28] == 4'b1110;
        priv     = (dest[31:24] == 8'd10) || (dest[31:24] == 8'd172 && dest[23:20] == 4'h1)
                   || (dest[31:24] == 8'd192 && dest[23:16] == 8'd168);
        dest_ok  = (((dest ^ cfg.dest_address) & cfg.subnet_mask) == 32'h0)
                   || (cfg.allow_public && !priv) || (cfg.allow_bc && bcast)
                   || (cfg.allow_mc && mcast);
        exp_done   = dest_in;
        exp_ports  = proto_in && ports;
        exp_udp    = proto_in && (proto == 8'd17);
        exp_poison = !dest_in || (proto_in && cfg.restrict_to_ports && !ports)
                     || (src_in && cfg.match_src && (src != cfg.src_address))
                     || (dest_in && !dest_ok);
    endtask

    task automatic build_frame(input logic [7:0] proto, input logic [31:0] src,
                               input logic [31:0] dest, input logic vlan);
        int shift;
        shift = vlan ? `IP4_VLAN_BYTES : 0;
        for (int i = 0; i < 64; i++) begin
            frame_bytes[i] = 8'($random(seed));
        end
        frame_bytes[`IP4_PROT_OFFSET + shift] = proto;
        for (int i = 0; i < 4; i++) begin
            frame_bytes[`IP4_SA_OFFSET + shift + i] = src[31 - 8 * i -: 8];
            frame_bytes[`IP4_DA_OFFSET + shift + i] = dest[31 - 8 * i -: 8];
        end
    endtask

    task automatic send_frame(input int nbeats, input logic stall);
        axis_beat_t beat;
        for (int b = 0; b < nbeats; b++) begin
            for (int k = 0; k < `IP4_BUS_BYTES; k++) begin
                beat.tdata[k * 8 +: 8] = frame_bytes[b * `IP4_BUS_BYTES + k];
            end
            beat.tkeep = '1;
            beat.tlast = (b == nbeats - 1);
            @(negedge aclk);
            s_beat     = beat;
            s_tvalid   = 1'b1;
            first_beat = (b == 0);
            m_tready   = stall ? (($random(seed) & 3) != 0) : 1'b1;
            @(posedge aclk);
            // Hold the beat until the sink takes it
            while (!m_tready) begin
                @(negedge aclk);
                m_tready = (($random(seed) & 3) != 0);
                @(posedge aclk);
            end
        end
        @(negedge aclk);
        s_tvalid   = 1'b0;
        first_beat = 1'b0;
        m_tready   = 1'b1;
    endtask

    task automatic run_frame(input logic [7:0] proto, input logic [31:0] src,
                             input logic [31:0] dest, input logic vlan,
                             input int nbeats, input logic stall);
        is_tagged = vlan;
        build_frame(proto, src, dest, vlan);
        expect_result(proto, src, dest, vlan, nbeats * `IP4_BUS_BYTES);
        send_frame(nbeats, stall);
        frames++;
    endtask

    task automatic protocol_frames(input logic vlan, input logic stall);
        cfg = base_cfg();
        cfg.restrict_to_ports = 1'b1;
        for (int i = 0; i < 7; i++) begin
            run_frame(PROTOS[i], SRC_OK, DESTS[0], vlan, 8, stall);
        end
    endtask

    task automatic source_frames(input logic vlan);
        cfg = base_cfg();
        cfg.match_src = 1'b1;
        run_frame(8'd6, SRC_OK, DESTS[0], vlan, 8, 1'b0);
        run_frame(8'd6, SRC_BAD, DESTS[0], vlan, 8, 1'b0);
        cfg.match_src = 1'b0;
        run_frame(8'd6, SRC_BAD, DESTS[0], vlan, 8, 1'b0);
    endtask

    task automatic dest_frames(input logic [2:0] allow, input logic vlan, input logic stall);
        cfg = base_cfg();
        {cfg.allow_public, cfg.allow_bc, cfg.allow_mc} = allow;
        for (int i = 0; i < 6; i++) begin
            run_frame(8'd17, SRC_OK, DESTS[i], vlan, 8, stall);
        end
    endtask

    task automatic start_test();
        test_errors0 = errors;
        test_frames0 = frames;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d frames, %0d errors", tests, name, frames - test_frames0,
                 errors - test_errors0);
    endtask

    initial begin
        seed       = 32'h2a1e_34ac;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        frames     = 0;
        rst        = 1'b1;
        s_beat     = '0;
        s_tvalid   = 1'b0;
        m_tready   = 1'b1;
        is_tagged  = 1'b0;
        cfg        = base_cfg();
        first_beat = 1'b0;
        exp_done   = 1'b0;
        exp_poison = 1'b0;
        exp_ports  = 1'b0;
        exp_udp    = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;

        start_test();
        protocol_frames(1'b0, 1'b0);
        end_test("protocol classification");

        start_test();
        source_frames(1'b0);
        end_test("source check");

        start_test();
        for (int a = 0; a < 8; a++) begin
            dest_frames(3'(a), 1'b0, 1'b0);
        end
        end_test("destination check");

        start_test();
        protocol_frames(1'b1, 1'b0);
        source_frames(1'b1);
        dest_frames(3'b010, 1'b1, 1'b0);
        end_test("vlan tag");

        // Full frame, untagged runt, tagged runt, full frame
        start_test();
        cfg = base_cfg();
        run_frame(8'd6, SRC_OK, DESTS[0], 1'b0, 8, 1'b0);
        run_frame(8'd6, SRC_OK, DESTS[0], 1'b0, 4, 1'b0);
        run_frame(8'd47, SRC_OK, DESTS[0], 1'b1, 4, 1'b0);
        run_frame(8'd17, SRC_OK, DESTS[0], 1'b0, 8, 1'b0);
        end_test("done and runt");

        start_test();
        protocol_frames(1'b0, 1'b1);
        dest_frames(3'b101, 1'b1, 1'b1);
        end_test("back-pressure");

        $display("tests %0d, frames %0d, checks %0d, errors %0d", tests, frames, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/axis_pkg.sv
common/ip4_pkg.sv
src/beat_counter.sv
src/frame_phase_fsm.sv
src/field_capture.sv
acl/dest_acl.sv
acl/header_acl.sv
src/ip4_parser.sv
sim/tb_ip4_parser.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the IPv4 parser testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_ip4_parser -Mdir obj_dir -f files.f

out=$(./obj_dir/Vtb_ip4_parser)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
else
    exit 1
fi
